// File: design/hash_lane.sv
/*
 * Hash lane
 * Mixes header with nonce_base plus LANE_INDEX and registers the
 * hash, the target compare, the nonce and the step flags
 */
`timescale 1ns/100ps
`default_nettype none

module hash_lane
	import miner_pkg::*;
#(
	parameter int LANE_INDEX = 0
)
(
	input  wire logic        tb_write_enable,
	input  wire logic        rst,
	input  wire logic        in_valid,
	input  wire logic        in_last,
	input  wire logic [31:0] nonce_base,
	input  wire logic [31:0] header,
	input  wire logic [31:0] target,
	output logic             out_valid,
	output logic             out_last,
	output logic             hit,
	output logic      [31:0] nonce,
	output logic      [31:0] hash
);

	logic [31:0] lane_nonce;
	logic [31:0] mix;

	assign lane_nonce = nonce_base + 32'(LANE_INDEX);
	assign mix = hash_mix(header, lane_nonce);

	always_ff @(posedge tb_write_enable)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			out_last <= 1'b0;
		end
		else
		begin
			out_valid <= in_valid;
			out_last <= in_valid && in_last;
		end
	end

	always_ff @(posedge tb_write_enable)
	begin
		nonce <= lane_nonce;
		hash <= mix;
		hit <= (mix < target);  // Unsigned compare
	end

endmodule

`default_nettype wire

// File: design/miner_pkg.sv
/*
 * Miner shared definitions
 * PID, command and decoder state encodings, protocol constants
 * and the 32-bit mixing rule that stands in for the block hash
 */
`default_nettype none

package miner_pkg;

	typedef enum logic [7:0]
	{
		PID_DATA0 = 8'hC3,
		PID_DATA1 = 8'h4B
	} pid_e;

	typedef enum logic [7:0]
	{
		CMD_HASH      = 8'h01,
		CMD_INTERRUPT = 8'h04
	} cmd_e;

	typedef enum logic [2:0]
	{
		IDLE,
		PID,
		CMD,
		PAYLOAD,
		CRC,
		WAIT_EOP
	} dec_state_e;

	localparam logic [7:0] SYNC_BYTE = 8'h80;          // LSB first on the wire
	localparam logic [31:0] NONCE_LIMIT = 32'd65536;
	localparam logic [15:0] CRC16_RESIDUE = 16'h800D;
	localparam int HASH_PAYLOAD_BYTES = 8;             // Header then target

	// Hit when result is below the target
	function automatic logic [31:0] hash_mix(input logic [31:0] header, input logic [31:0] nonce);
		logic [31:0] x;
		x = header ^ nonce;
		x = x ^ {x[24:0], x[31:25]};  // rotl 7
		x = x + 32'h9E3779B9;
		x = x ^ {x[12:0], x[31:13]};  // rotr 13
		return x;
	endfunction

endpackage

`default_nettype wire

// File: design/miner_top.sv
/*
 * Nonce search engine top level
 * USB receive path, job dispatch, parallel hash lanes and result collection
 */
`timescale 1ns/100ps
`default_nettype none

module miner_top
#(
	parameter int NUM_LANES = 4,
	parameter int CLKS_PER_BIT = 4
)
(
	input  wire logic        tb_write_enable,
	input  wire logic        rst,
	input  wire logic        d_plus,
	input  wire logic        d_minus,
	output logic             result_valid,
	output logic             result_found,
	output logic      [31:0] result_nonce,
	output logic      [31:0] result_hash,
	output logic             busy,
	output logic             rx_error
);

	logic [7:0] rx_byte;
	logic byte_strobe;
	logic sof_strobe;
	logic eop_strobe;
	logic phy_error;
	logic job_start;
	logic job_abort;
	logic [31:0] job_header;
	logic [31:0] job_target;
	logic lane_valid;
	logic lane_last;
	logic [31:0] nonce_base;
	logic [31:0] lane_header;
	logic [31:0] lane_target;
	logic stop;
	logic [NUM_LANES-1:0] lane_out_valid;
	logic [NUM_LANES-1:0] lane_out_last;
	logic [NUM_LANES-1:0] lane_hit;
	logic [NUM_LANES-1:0][31:0] lane_nonce;
	logic [NUM_LANES-1:0][31:0] lane_hash;

	usb_rx_phy #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_phy (
		.tb_write_enable, .rst,
		.d_plus, .d_minus,
		.rx_byte, .byte_strobe,
		.sof_strobe, .eop_strobe,
		.phy_error
	);

	packet_decoder u_decoder (
		.tb_write_enable, .rst,
		.rx_byte, .byte_strobe,
		.sof_strobe, .eop_strobe,
		.phy_error,
		.job_start, .job_abort,
		.job_header, .job_target,
		.rx_error
	);

	nonce_dispatch #(.NUM_LANES(NUM_LANES)) u_dispatch (
		.tb_write_enable, .rst,
		.job_start, .job_abort,
		.job_header, .job_target,
		.stop, .busy,
		.lane_valid, .lane_last,
		.nonce_base, .lane_header, .lane_target
	);

	for (genvar i = 0; i < NUM_LANES; i++)
	begin : g_lane
		hash_lane #(.LANE_INDEX(i)) u_lane (
			.tb_write_enable, .rst,
			.in_valid(lane_valid), .in_last(lane_last),
			.nonce_base, .header(lane_header), .target(lane_target),
			.out_valid(lane_out_valid[i]), .out_last(lane_out_last[i]),
			.hit(lane_hit[i]), .nonce(lane_nonce[i]), .hash(lane_hash[i])
		);
	end

	result_collector #(.NUM_LANES(NUM_LANES)) u_collector (
		.tb_write_enable, .rst,
		.lane_out_valid, .lane_out_last,
		.lane_hit, .lane_nonce, .lane_hash,
		.job_start, .job_abort,
		.stop, .result_valid, .result_found,
		.result_nonce, .result_hash
	);

endmodule

`default_nettype wire

// File: design/nonce_dispatch.sv
/*
 * Nonce dispatcher
 * Holds the current job and issues one step of NUM_LANES nonces
 * per cycle until a hit, an abort or the nonce limit
 */
`timescale 1ns/100ps
`default_nettype none

module nonce_dispatch
	import miner_pkg::*;
#(
	parameter int NUM_LANES = 4
)
(
	input  wire logic        tb_write_enable,
	input  wire logic        rst,
	input  wire logic        job_start,
	input  wire logic        job_abort,
	input  wire logic [31:0] job_header,
	input  wire logic [31:0] job_target,
	input  wire logic        stop,
	output logic             busy,
	output logic             lane_valid,
	output logic             lane_last,
	output logic      [31:0] nonce_base,
	output logic      [31:0] lane_header,
	output logic      [31:0] lane_target
);

	localparam logic [31:0] STEP = 32'(NUM_LANES);
	localparam logic [31:0] LAST_BASE = NONCE_LIMIT - STEP;

	assign lane_valid = busy;

	always_ff @(posedge tb_write_enable)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			lane_last <= 1'b0;
		end
		else if (job_start)
		begin
			busy <= 1'b1;  // Restarts even when already busy
			lane_last <= (LAST_BASE == 32'd0);
		end
		else if (busy)
		begin
			if (stop || job_abort || lane_last)
			begin
				busy <= 1'b0;
				lane_last <= 1'b0;
			end
			else
				lane_last <= (nonce_base + STEP == LAST_BASE);
		end
	end

	always_ff @(posedge tb_write_enable)
	begin
		if (job_start)
		begin
			nonce_base <= '0;
			lane_header <= job_header;
			lane_target <= job_target;
		end
		else if (busy)
			nonce_base <= nonce_base + STEP;
	end

endmodule

`default_nettype wire

// File: design/packet_decoder.sv
/*
 * Packet decoder
 * Checks the data PID, decodes the command, stages the payload,
 * checks the USB CRC16 residue and issues job start or abort
 */
`timescale 1ns/100ps
`default_nettype none

module packet_decoder
	import miner_pkg::*;
(
	input  wire logic        tb_write_enable,
	input  wire logic        rst,
	input  wire logic  [7:0] rx_byte,
	input  wire logic        byte_strobe,
	input  wire logic        sof_strobe,
	input  wire logic        eop_strobe,
	input  wire logic        phy_error,
	output logic             job_start,
	output logic             job_abort,
	output logic      [31:0] job_header,
	output logic      [31:0] job_target,
	output logic             rx_error
);

	dec_state_e state;
	cmd_e cmd;
	logic bad;
	logic [15:0] crc;
	logic [2:0] pay_cnt;
	logic crc_cnt;
	logic [63:0] stage;
	logic pkt_ok;

	// Serial USB CRC16, each byte fed LSB first
	function automatic logic [15:0] crc16_byte(input logic [15:0] crc_in, input logic [7:0] data);
		logic [15:0] c;
		c = crc_in;
		for (int i = 0; i < 8; i++)
		begin
			if (data[i] ^ c[15])
				c = {c[14:0], 1'b0} ^ 16'h8005;
			else
				c = {c[14:0], 1'b0};
		end
		return c;
	endfunction

	assign pkt_ok = eop_strobe && (state == WAIT_EOP) && !bad && (crc == CRC16_RESIDUE);

	always_ff @(posedge tb_write_enable)
	begin
		if (rst)
		begin
			state <= IDLE;
			cmd <= CMD_HASH;
			bad <= 1'b0;
			crc <= 16'hFFFF;
			pay_cnt <= '0;
			crc_cnt <= 1'b0;
			job_start <= 1'b0;
			job_abort <= 1'b0;
			rx_error <= 1'b0;
		end
		else
		begin
			job_start <= 1'b0;
			job_abort <= 1'b0;
			rx_error <= 1'b0;
			if (sof_strobe)
			begin
				state <= PID;
				bad <= 1'b0;
				crc <= 16'hFFFF;
			end
			else if (eop_strobe)
			begin
				if (pkt_ok)
				begin
					job_start <= (cmd == CMD_HASH);
					job_abort <= (cmd == CMD_INTERRUPT);
				end
				else if (state != IDLE)
					rx_error <= 1'b1;  // Short packet, bad CRC or earlier fault
				state <= IDLE;
			end
			else if (phy_error && state != IDLE)
			begin
				bad <= 1'b1;
				state <= WAIT_EOP;
			end
			else if (byte_strobe)
			begin
				if (state != IDLE && state != PID)
					crc <= crc16_byte(crc, rx_byte);
				case (state)
					PID:
						if (rx_byte == PID_DATA0 || rx_byte == PID_DATA1)
							state <= CMD;
						else
						begin
							bad <= 1'b1;
							state <= WAIT_EOP;
						end
					CMD:
						case (rx_byte)
							CMD_HASH:
							begin
								cmd <= CMD_HASH;
								pay_cnt <= '0;
								state <= PAYLOAD;
							end
							CMD_INTERRUPT:
							begin
								cmd <= CMD_INTERRUPT;
								crc_cnt <= 1'b0;
								state <= CRC;
							end
							default:
							begin
								bad <= 1'b1;
								state <= WAIT_EOP;
							end
						endcase
					PAYLOAD:
					begin
						pay_cnt <= pay_cnt + 1'b1;
						crc_cnt <= 1'b0;
						if (pay_cnt == 3'(HASH_PAYLOAD_BYTES - 1))
							state <= CRC;
					end
					CRC:
					begin
						crc_cnt <= 1'b1;
						if (crc_cnt)
							state <= WAIT_EOP;
					end
					WAIT_EOP: bad <= 1'b1;  // Too many bytes
					default: ;
				endcase
			end
		end
	end

	// Header bytes 0..3 then target bytes 4..7, LSB first
	always_ff @(posedge tb_write_enable)
	begin
		if (byte_strobe && state == PAYLOAD)
			stage <= {rx_byte, stage[63:8]};
		if (pkt_ok && cmd == CMD_HASH)
		begin
			job_header <= stage[31:0];
			job_target <= stage[63:32];
		end
	end

endmodule

`default_nettype wire

// File: design/result_collector.sv
/*
 * Result collector
 * Picks the lowest hitting lane of each step, reports found or
 * not found, and drops steps still in flight after a result
 */
`timescale 1ns/100ps
`default_nettype none

module result_collector
#(
	parameter int NUM_LANES = 4
)
(
	input  wire logic                        tb_write_enable,
	input  wire logic                        rst,
	input  wire logic        [NUM_LANES-1:0] lane_out_valid,
	input  wire logic        [NUM_LANES-1:0] lane_out_last,
	input  wire logic        [NUM_LANES-1:0] lane_hit,
	input  wire logic [NUM_LANES-1:0][31:0] lane_nonce,
	input  wire logic [NUM_LANES-1:0][31:0] lane_hash,
	input  wire logic                        job_start,
	input  wire logic                        job_abort,
	output logic                             stop,
	output logic                             result_valid,
	output logic                             result_found,
	output logic                      [31:0] result_nonce,
	output logic                      [31:0] result_hash
);

	localparam int SEL_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	logic [SEL_W-1:0] sel;
	logic any_hit;
	logic step_last;
	logic armed;
	logic arm_pending;
	logic accept;

	// Lowest index wins
	always_comb
	begin
		sel = '0;
		any_hit = 1'b0;
		for (int i = NUM_LANES - 1; i >= 0; i--)
		begin
			if (lane_out_valid[i] && lane_hit[i])
			begin
				sel = SEL_W'(i);
				any_hit = 1'b1;
			end
		end
	end

	assign step_last = |(lane_out_valid & lane_out_last);
	assign accept = armed && !job_start && !job_abort && (any_hit || step_last);
	assign stop = result_valid && result_found;

	always_ff @(posedge tb_write_enable)
	begin
		if (rst)
		begin
			armed <= 1'b0;
			arm_pending <= 1'b0;
			result_valid <= 1'b0;
			result_found <= 1'b0;
		end
		else
		begin
			result_valid <= accept;
			result_found <= accept && any_hit;
			arm_pending <= job_start;
			if (job_start || job_abort || accept)
				armed <= 1'b0;
			else if (arm_pending)
				armed <= 1'b1;  // First step of the new job is now at the lanes
		end
	end

	always_ff @(posedge tb_write_enable)
	begin
		if (accept)
		begin
			result_nonce <= any_hit ? lane_nonce[sel] : 32'd0;
			result_hash <= any_hit ? lane_hash[sel] : 32'd0;
		end
	end

endmodule

`default_nettype wire

// File: design/usb_rx_phy.sv
/*
 * USB receive PHY
 * Mid-bit sampling of d_plus/d_minus, NRZI decode, bit unstuffing,
 * SYNC and EOP detection and byte assembly, LSB first
 */
`timescale 1ns/100ps
`default_nettype none

module usb_rx_phy
	import miner_pkg::*;
#(
	parameter int CLKS_PER_BIT = 4
)
(
	input  wire logic       tb_write_enable,
	input  wire logic       rst,
	input  wire logic       d_plus,
	input  wire logic       d_minus,
	output logic      [7:0] rx_byte,
	output logic            byte_strobe,
	output logic            sof_strobe,
	output logic            eop_strobe,
	output logic            phy_error
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT) + 1;
	localparam logic [1:0] LINE_J = 2'b10;
	localparam logic [1:0] LINE_SE0 = 2'b00;

	logic [1:0] line_q;
	logic [1:0] line_prev;
	logic [CNT_W-1:0] bit_timer;
	logic active;
	logic in_sync;
	logic rx_abort;
	logic prev_level;
	logic [2:0] ones_cnt;
	logic [2:0] bit_cnt;
	logic [1:0] se0_cnt;
	logic [7:0] shift_reg;
	logic line_edge;
	logic sample;
	logic rx_bit;
	logic [7:0] shift_next;

	assign line_edge = (line_q != line_prev);
	assign sample = active && (bit_timer == CNT_W'(CLKS_PER_BIT / 2 - 1));
	assign rx_bit = (line_q[1] == prev_level);  // No transition is a one
	assign shift_next = {rx_bit, shift_reg[7:1]};
	assign rx_byte = shift_reg;

	always_ff @(posedge tb_write_enable)
	begin
		if (rst)
		begin
			line_q <= LINE_J;
			line_prev <= LINE_J;
			bit_timer <= '0;
		end
		else
		begin
			line_q <= {d_plus, d_minus};
			line_prev <= line_q;
			// Resync on every transition
			if (line_edge || bit_timer == CNT_W'(CLKS_PER_BIT - 1))
				bit_timer <= '0;
			else
				bit_timer <= bit_timer + 1'b1;
		end
	end

	always_ff @(posedge tb_write_enable)
	begin
		if (rst)
		begin
			active <= 1'b0;
			in_sync <= 1'b0;
			rx_abort <= 1'b0;
			prev_level <= 1'b1;
			ones_cnt <= '0;
			bit_cnt <= '0;
			se0_cnt <= '0;
			shift_reg <= '0;
			byte_strobe <= 1'b0;
			sof_strobe <= 1'b0;
			eop_strobe <= 1'b0;
			phy_error <= 1'b0;
		end
		else
		begin
			byte_strobe <= 1'b0;
			sof_strobe <= 1'b0;
			eop_strobe <= 1'b0;
			phy_error <= 1'b0;
			if (!active)
			begin
				in_sync <= 1'b0;
				rx_abort <= 1'b0;
				prev_level <= 1'b1;
				se0_cnt <= '0;
				shift_reg <= '0;
				if (line_q != LINE_J)
					active <= 1'b1;  // First edge away from idle
			end
			else if (sample)
			begin
				if (line_q == LINE_SE0)
				begin
					in_sync <= 1'b0;
					rx_abort <= 1'b1;
					if (se0_cnt != 2'd3)
						se0_cnt <= se0_cnt + 1'b1;
				end
				else if (se0_cnt >= 2'd2 && line_q == LINE_J)
				begin
					eop_strobe <= 1'b1;
					active <= 1'b0;
				end
				else
				begin
					se0_cnt <= '0;
					prev_level <= line_q[1];
					if (!in_sync && !rx_abort)
					begin
						shift_reg <= shift_next;
						if (shift_next == SYNC_BYTE)
						begin
							sof_strobe <= 1'b1;
							in_sync <= 1'b1;
							bit_cnt <= '0;
							ones_cnt <= '0;
						end
					end
					else if (in_sync && ones_cnt == 3'd6)
					begin
						ones_cnt <= '0;  // Stuffed bit dropped
						if (rx_bit)
						begin
							phy_error <= 1'b1;
							in_sync <= 1'b0;
							rx_abort <= 1'b1;
						end
					end
					else if (in_sync)
					begin
						ones_cnt <= rx_bit ? ones_cnt + 1'b1 : 3'd0;
						shift_reg <= shift_next;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							byte_strobe <= 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: project.f
design/miner_pkg.sv
design/usb_rx_phy.sv
design/packet_decoder.sv
design/nonce_dispatch.sv
design/hash_lane.sv
design/result_collector.sv
design/miner_top.sv
tests/miner_properties.sv
tests/tb_miner.sv

// File: tests/miner_properties.sv
/*
 * Miner result and status assertions
 * Bound into the miner top level
 */
`timescale 1ns/100ps
`default_nettype none

module miner_properties
(
	input wire logic tb_write_enable,
	input wire logic rst,
	input wire logic result_valid,
	input wire logic result_found,
	input wire logic busy,
	input wire logic rx_error,
	input wire logic job_start
);

	int violations = 0;

	valid_one_cycle: assert property (@(posedge tb_write_enable) disable iff (rst)
		result_valid |=> !result_valid)
	else
	begin
		violations++;
		$error("result_valid held for more than one cycle");
	end

	found_needs_valid: assert property (@(posedge tb_write_enable) disable iff (rst)
		result_found |-> result_valid)
	else
	begin
		violations++;
		$error("result_found high without result_valid");
	end

	idle_after_result: assert property (@(posedge tb_write_enable) disable iff (rst)
		result_valid |=> !busy)
	else
	begin
		violations++;
		$error("busy still high after result_valid");
	end

	no_start_on_error: assert property (@(posedge tb_write_enable) disable iff (rst)
		!(rx_error && job_start))
	else
	begin
		violations++;
		$error("rx_error and job_start in the same cycle");
	end

endmodule

bind miner_top miner_properties u_props (
	.tb_write_enable, .rst,
	.result_valid, .result_found,
	.busy, .rx_error, .job_start
);

`default_nettype wire

// File: tests/tb_miner.sv
/*
 * Testbench for the nonce search engine
 * Sends USB data packets from a table and checks the results
 * against a software model of the mixing rule and first-hit search
 */
`timescale 1ns/100ps
`default_nettype none

module tb_miner
	import miner_pkg::*;
();

	localparam int NUM_LANES = 4;
	localparam int CLKS_PER_BIT = 4;
	localparam int NUM_ROWS = 8;
	localparam int PKT_BITS = 130;  // Sync, PID, cmd, payload, CRC, stuffing, EOP
	localparam int MARGIN = 400;
	localparam int SEARCH_CYCLES = int'(NONCE_LIMIT) / NUM_LANES;
	localparam int TIMEOUT_CYCLES =
		NUM_ROWS * (2 * PKT_BITS * CLKS_PER_BIT + SEARCH_CYCLES + MARGIN);
	localparam int RESULT_WAIT = SEARCH_CYCLES + 64;
	localparam int PULSE_WAIT = 64;

	logic tb_write_enable;
	logic rst;
	logic d_plus;
	logic d_minus;
	logic result_valid;
	logic result_found;
	logic [31:0] result_nonce;
	logic [31:0] result_hash;
	logic busy;
	logic rx_error;

	// Stimulus and expected values, one entry per row
	logic [7:0] row_pid [NUM_ROWS];
	logic [7:0] row_cmd [NUM_ROWS];
	logic [31:0] row_header [NUM_ROWS];
	logic [31:0] row_target [NUM_ROWS];
	logic row_corrupt [NUM_ROWS];
	int row_abort_after [NUM_ROWS];
	logic row_exp_found [NUM_ROWS];
	logic [31:0] row_exp_nonce [NUM_ROWS];
	logic [31:0] row_exp_hash [NUM_ROWS];

	int result_count = 0;
	int error_count = 0;
	int cycle_count = 0;
	logic got_found;
	logic [31:0] got_nonce;
	logic [31:0] got_hash;
	integer seed;
	logic line_level;
	int ones_run;
	logic [7:0] body [$];

	miner_top #(.NUM_LANES(NUM_LANES), .CLKS_PER_BIT(CLKS_PER_BIT)) u_dut (
		.tb_write_enable, .rst,
		.d_plus, .d_minus,
		.result_valid, .result_found,
		.result_nonce, .result_hash,
		.busy, .rx_error
	);

	initial
		tb_write_enable = 1'b0;

	always #2 tb_write_enable = ~tb_write_enable;

	always @(posedge tb_write_enable)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end
	end

	// Pulse capture at mid-cycle
	always @(negedge tb_write_enable)
	begin
		if (result_valid)
		begin
			result_count <= result_count + 1;
			got_found <= result_found;
			got_nonce <= result_nonce;
			got_hash <= result_hash;
		end
		if (rx_error)
			error_count <= error_count + 1;
	end

	function automatic logic [31:0] rotl(input logic [31:0] v, input int n);
		return (v << n) | (v >> (32 - n));
	endfunction

	function automatic logic [31:0] model_mix(input logic [31:0] header, input logic [31:0] nonce);
		logic [31:0] x;
		x = header ^ nonce;
		x = x ^ rotl(x, 7);
		x = x + 32'h9E3779B9;
		x = x ^ rotl(x, 19);  // Same as rotate right by 13
		return x;
	endfunction

	// Reflected USB CRC16, polynomial 8005 mirrored
	function automatic logic [15:0] crc16_update(input logic [15:0] crc, input logic [7:0] data);
		for (int i = 0; i < 8; i++)
		begin
			if (crc[0] ^ data[i])
				crc = (crc >> 1) ^ 16'hA001;
			else
				crc = crc >> 1;
		end
		return crc;
	endfunction

	task automatic find_first_hit(input int row);
		logic [31:0] h;
		row_exp_found[row] = 1'b0;
		row_exp_nonce[row] = '0;
		row_exp_hash[row] = '0;
		for (int n = 0; n < int'(NONCE_LIMIT) && !row_exp_found[row]; n++)
		begin
			h = model_mix(row_header[row], n);
			if (h < row_target[row])
			begin
				row_exp_found[row] = 1'b1;
				row_exp_nonce[row] = n;
				row_exp_hash[row] = h;
			end
		end
	endtask

	task automatic set_row(input int row, input logic [7:0] pid, input logic [7:0] cmd,
		input logic [31:0] header, input logic [31:0] target, input logic corrupt,
		input int abort_after);
		row_pid[row] = pid;
		row_cmd[row] = cmd;
		row_header[row] = header;
		row_target[row] = target;
		row_corrupt[row] = corrupt;
		row_abort_after[row] = abort_after;
		find_first_hit(row);
	endtask

	task automatic build_table();
		set_row(0, PID_DATA0, CMD_HASH, $random(seed), 32'h0010_0000, 1'b0, 0);
		set_row(1, PID_DATA1, CMD_HASH, $random(seed) | 32'hFF, 32'h0020_0000, 1'b0, 0);
		set_row(2, PID_DATA0, CMD_HASH, $random(seed), 32'h0010_0000, 1'b1, 0);
		set_row(3, 8'hD2, CMD_HASH, $random(seed), 32'h0010_0000, 1'b0, 0);  // ACK handshake
		set_row(4, PID_DATA0, 8'h07, $random(seed), 32'h0010_0000, 1'b0, 0);
		set_row(5, PID_DATA0, CMD_HASH, $random(seed), 32'h0, 1'b0, 0);
		set_row(6, PID_DATA0, CMD_HASH, $random(seed), 32'h0, 1'b0, 40);
		set_row(7, PID_DATA1, CMD_HASH, $random(seed), 32'h0008_0000, 1'b0, 0);
	endtask

	function automatic logic rejected(input int row);
		return row_corrupt[row] || !(row_pid[row] == PID_DATA0 || row_pid[row] == PID_DATA1)
			|| !(row_cmd[row] == CMD_HASH || row_cmd[row] == CMD_INTERRUPT);
	endfunction

	task automatic hold_line(input logic dp, input logic dm);
		d_plus = dp;
		d_minus = dm;
		repeat (CLKS_PER_BIT) @(negedge tb_write_enable);
	endtask

	task automatic send_nrzi(input logic b);
		if (!b)
			line_level = ~line_level;  // A zero toggles the line
		hold_line(line_level, ~line_level);
	endtask

	task automatic send_data_bit(input logic b);
		send_nrzi(b);
		ones_run = b ? ones_run + 1 : 0;
		if (ones_run == 6)
		begin
			send_nrzi(1'b0);
			ones_run = 0;
		end
	endtask

	task automatic send_packet(input logic [7:0] pid, input logic [7:0] cmd,
		input logic [31:0] header, input logic [31:0] target, input logic corrupt);
		logic [15:0] crc;
		body.delete();
		body.push_back(cmd);
		if (cmd == CMD_HASH)
		begin
			for (int i = 0; i < 4; i++)
				body.push_back(header[8*i +: 8]);
			for (int i = 0; i < 4; i++)
				body.push_back(target[8*i +: 8]);
		end
		crc = 16'hFFFF;
		foreach (body[j])
			crc = crc16_update(crc, body[j]);
		crc = ~crc;
		body.push_back(crc[7:0] ^ {7'd0, corrupt});
		body.push_back(crc[15:8]);
		line_level = 1'b1;
		for (int i = 0; i < 8; i++)
			send_nrzi(SYNC_BYTE[i]);
		ones_run = 0;
		for (int i = 0; i < 8; i++)
			send_data_bit(pid[i]);
		foreach (body[j])
			for (int i = 0; i < 8; i++)
				send_data_bit(body[j][i]);
		hold_line(1'b0, 1'b0);
		hold_line(1'b0, 1'b0);
		repeat (3) hold_line(1'b1, 1'b0);  // J, then idle
	endtask

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic check_result(input int row, input int res_before, input int err_before);
		int waited;
		waited = 0;
		while (result_count == res_before && waited < RESULT_WAIT)
		begin
			@(negedge tb_write_enable);
			waited++;
		end
		if (result_count == res_before)
			fail_run($sformatf("No result_valid pulse for row %0d", row));
		check_bit("result_found", row_exp_found[row], got_found);
		if (row_exp_found[row])
		begin
			check_word("result_nonce", row_exp_nonce[row], got_nonce);
			check_word("result_hash", row_exp_hash[row], got_hash);
		end
		repeat (8) @(negedge tb_write_enable);
		if (result_count != res_before + 1)
			fail_run($sformatf("Extra result_valid pulse for row %0d", row));
		if (error_count != err_before)
			fail_run($sformatf("rx_error pulsed on the good packet of row %0d", row));
		check_bit("busy", 1'b0, busy);
	endtask

	task automatic check_error(input int row, input int res_before, input int err_before);
		int waited;
		waited = 0;
		while (error_count == err_before && waited < PULSE_WAIT)
		begin
			check_bit("busy", 1'b0, busy);
			@(negedge tb_write_enable);
			waited++;
		end
		if (error_count == err_before)
			fail_run($sformatf("No rx_error pulse for the bad packet of row %0d", row));
		repeat (8)
		begin
			check_bit("busy", 1'b0, busy);
			@(negedge tb_write_enable);
		end
		if (result_count != res_before)
			fail_run($sformatf("A result was reported for the bad packet of row %0d", row));
	endtask

	task automatic run_abort(input int row, input int res_before, input int err_before);
		int waited;
		waited = 0;
		while (!busy && waited < PULSE_WAIT)
		begin
			@(negedge tb_write_enable);
			waited++;
		end
		if (!busy)
			fail_run($sformatf("busy never rose for the job of row %0d", row));
		repeat (row_abort_after[row]) @(negedge tb_write_enable);
		send_packet(PID_DATA0, CMD_INTERRUPT, 32'h0, 32'h0, 1'b0);
		waited = 0;
		while (busy && waited < PULSE_WAIT)
		begin
			@(negedge tb_write_enable);
			waited++;
		end
		check_bit("busy", 1'b0, busy);
		repeat (8) @(negedge tb_write_enable);
		if (result_count != res_before)
			fail_run($sformatf("A result was reported after the interrupt in row %0d", row));
		if (error_count != err_before)
			fail_run($sformatf("rx_error pulsed on the interrupt of row %0d", row));
	endtask

	initial
	begin
		int res_before;
		int err_before;
		seed = 82474;
		rst = 1'b1;
		d_plus = 1'b1;  // Idle J
		d_minus = 1'b0;
		line_level = 1'b1;
		ones_run = 0;
		build_table();
		repeat (3) @(negedge tb_write_enable);
		rst = 1'b0;
		repeat (4) @(negedge tb_write_enable);
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			res_before = result_count;
			err_before = error_count;
			send_packet(row_pid[r], row_cmd[r], row_header[r], row_target[r], row_corrupt[r]);
			if (rejected(r))
				check_error(r, res_before, err_before);
			else if (row_abort_after[r] > 0)
				run_abort(r, res_before, err_before);
			else
				check_result(r, res_before, err_before);
		end
		if (u_dut.u_props.violations == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
